// File: Bender.yml
package:
  name: sssp_tile

sources:
  - hw/sssp_pkg.sv
  - hw/sssp_task_fsm.sv
  - hw/sssp_burst_counter.sv
  - hw/sssp_dist_store.sv
  - hw/sssp_rw.sv
  - hw/sssp_ro.sv
  - hw/sssp_tile.sv
  - target: test
    files:
      - tests/sssp_tile_tb.sv

// File: hw/sssp_burst_counter.sv
module sssp_burst_counter (
   input  logic                  clk,
   input  logic                  rstn,

   input  logic                  load,     // Neighbor read request accepted
   input  sssp_pkg::burst_len_t  load_len, // Beats of that read minus one
   input  logic                  beat,     // One child handed off

   output logic                  last
);

   sssp_pkg::burst_len_t remaining; // Beats still owed after the current one

   always_ff @(posedge clk) begin
      if (!rstn) begin
         remaining <= '0;
      end else if (load) begin
         remaining <= load_len;
      end else if (beat && (remaining != '0)) begin
         remaining <= remaining - 8'd1; // Holds at zero once the burst is done
      end
   end

   // Zero left means the beat on the bus right now closes the burst
   assign last = (remaining == '0);

endmodule

// File: hw/sssp_dist_store.sv
module sssp_dist_store (
   input  logic                clk,
   input  logic                rstn,

   input  sssp_pkg::node_t     rd_node,
   output sssp_pkg::rw_data_t  rd_dist,

   input  logic                we,
   input  sssp_pkg::node_t     wr_node,
   input  sssp_pkg::ts_t       wr_dist
);

   sssp_pkg::rw_data_t dist_q [sssp_pkg::NUM_NODES];

   // Only the low node bits select an entry, so indices wrap
   logic [sssp_pkg::NODE_IDX_W-1:0] rd_idx;
   logic [sssp_pkg::NODE_IDX_W-1:0] wr_idx;

   assign rd_idx  = rd_node[sssp_pkg::NODE_IDX_W-1:0];
   assign wr_idx  = wr_node[sssp_pkg::NODE_IDX_W-1:0];
   assign rd_dist = dist_q[rd_idx]; // Combinational read, ready in the RW cycle

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < sssp_pkg::NUM_NODES; i++) dist_q[i] <= sssp_pkg::DIST_INF;
      end else if (we) begin
         dist_q[wr_idx] <= wr_dist;
      end
   end

endmodule

// File: hw/sssp_pkg.sv
package sssp_pkg;

   // Widths that carry a meaning in the datapath
   typedef logic [31:0] node_t;       // Node index
   typedef logic [31:0] ts_t;         // Timestamp, which is also the tentative distance
   typedef logic [31:0] addr_t;       // Byte address into graph or distance memory
   typedef logic [63:0] graph_word_t; // Offset pair or neighbor/weight pair
   typedef logic [31:0] rw_data_t;    // Stored distance, same width as ts_t
   typedef logic [7:0]  burst_len_t;  // Beats of a read minus one

   // One unit of work moving through the tile
   typedef struct packed {
      ts_t         ts;
      node_t       object;
      logic [3:0]  ttype;
   } task_t;

   // Configuration writes have no ready and land on any cycle with wvalid
   typedef struct packed {
      logic        wvalid;
      logic [7:0]  waddr;
      logic [31:0] wdata;
   } reg_bus_t;

   typedef struct packed {
      addr_t       addr;
      burst_len_t  len;
   } ar_req_t;

   // One task walks these phases in order, with early exits back to idle
   typedef enum logic [2:0] {
      PH_IDLE,
      PH_RW,
      PH_OFFS_REQ,
      PH_OFFS_WAIT,
      PH_NBR_REQ,
      PH_NBR_STREAM
   } phase_e;

   localparam int NUM_NODES  = 16;
   localparam int NODE_IDX_W = $clog2(NUM_NODES); // Low node bits that index the store
   localparam ts_t DIST_INF  = '1;                // Unreached node

   localparam logic [7:0] REG_RW_BASE     = 8'd8;
   localparam logic [7:0] REG_OFFSET_BASE = 8'd12;
   localparam logic [7:0] REG_NBR_BASE    = 8'd16;

   localparam logic [3:0] CHILD_TTYPE = 4'd0;

endpackage

// File: hw/sssp_ro.sv
module sssp_ro (
   input  logic                   clk,
   input  logic                   rstn,

   input  sssp_pkg::reg_bus_t     reg_bus,
   input  sssp_pkg::phase_e       phase,
   input  sssp_pkg::task_t        cur_task,
   input  sssp_pkg::graph_word_t  r_data,

   output sssp_pkg::ar_req_t      ar,
   output logic                   range_empty, // Node has no outgoing edges
   output sssp_pkg::task_t        out_task
);

   sssp_pkg::addr_t       offs_base;
   sssp_pkg::addr_t       nbr_base;
   sssp_pkg::graph_word_t offs_word; // Start index low, end index high
   logic [31:0]           span;      // Edge count minus one

   always_ff @(posedge clk) begin
      if (!rstn) begin
         offs_base <= '0;
         nbr_base  <= '0;
      end else if (reg_bus.wvalid) begin
         case (reg_bus.waddr)
            sssp_pkg::REG_OFFSET_BASE: offs_base <= {reg_bus.wdata[29:0], 2'b00};
            sssp_pkg::REG_NBR_BASE:    nbr_base  <= {reg_bus.wdata[29:0], 2'b00};
            default: ;
         endcase
      end
   end

   // Sampled every waiting cycle, so the value left behind is the one from the beat
   always_ff @(posedge clk) begin
      if (phase == sssp_pkg::PH_OFFS_WAIT) offs_word <= r_data;
   end

   // An inverted range counts as empty too, it would only underflow the length
   assign range_empty = (phase == sssp_pkg::PH_OFFS_WAIT) && (r_data[63:32] <= r_data[31:0]);

   assign span = offs_word[63:32] - offs_word[31:0] - 32'd1;

   always_comb begin
      ar.addr = offs_base + {cur_task.object[28:0], 3'b000}; // Eight bytes per offset pair
      ar.len  = '0;
      if (phase == sssp_pkg::PH_NBR_REQ) begin
         ar.addr = nbr_base + {offs_word[28:0], 3'b000}; // Eight bytes per neighbor
         ar.len  = span[7:0];
      end
   end

   // Each neighbor beat turns into a child in the same cycle
   always_comb begin
      out_task.object = r_data[31:0];
      out_task.ts     = cur_task.ts + r_data[63:32]; // Parent distance plus edge weight
      out_task.ttype  = sssp_pkg::CHILD_TTYPE;
   end

endmodule

// File: hw/sssp_rw.sv
module sssp_rw (
   input  logic                clk,
   input  logic                rstn,

   input  sssp_pkg::reg_bus_t  reg_bus,
   input  sssp_pkg::phase_e    phase,
   input  sssp_pkg::task_t     cur_task,
   input  sssp_pkg::rw_data_t  cur_dist, // Stored distance of cur_task.object

   output logic                improve,
   output logic                wvalid,
   output sssp_pkg::addr_t     waddr,
   output sssp_pkg::ts_t       wdata
);

   sssp_pkg::addr_t rw_base; // Byte base of the distance array

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rw_base <= '0;
      end else if (reg_bus.wvalid && (reg_bus.waddr == sssp_pkg::REG_RW_BASE)) begin
         rw_base <= {reg_bus.wdata[29:0], 2'b00}; // Register holds a word address
      end
   end

   // Strictly smaller timestamps win, equal ones are dropped
   always_comb begin
      improve = 1'b0;
      if ((phase == sssp_pkg::PH_RW) && (cur_dist > cur_task.ts)) improve = 1'b1;
   end

   assign wvalid = improve;                                     // The write is the improvement
   assign waddr  = rw_base + {cur_task.object[29:0], 2'b00};    // Four bytes per distance
   assign wdata  = cur_task.ts;

endmodule

// File: hw/sssp_task_fsm.sv
module sssp_task_fsm (
   input  logic               clk,
   input  logic               rstn,

   input  logic               task_in_valid,
   output logic               task_in_ready,
   input  sssp_pkg::task_t    in_task,
   output sssp_pkg::task_t    cur_task,

   input  logic               improve,     // Task beats the stored distance

   output logic               ar_valid,
   input  logic               ar_ready,
   input  logic               r_valid,
   output logic               r_ready,

   input  logic               range_empty, // Offset word shows no neighbors
   input  logic               out_ready,
   output logic               out_valid,
   input  logic               burst_last,  // Current neighbor beat is the final one

   output sssp_pkg::phase_e   phase
);

   sssp_pkg::phase_e phase_d;

   logic accept;
   logic stream_beat;

   assign accept      = task_in_valid && task_in_ready;
   assign stream_beat = (phase == sssp_pkg::PH_NBR_STREAM) && r_valid && out_ready;

   // Handshake outputs come straight from the phase
   assign task_in_ready = (phase == sssp_pkg::PH_IDLE);
   assign ar_valid      = (phase == sssp_pkg::PH_OFFS_REQ) || (phase == sssp_pkg::PH_NBR_REQ);
   assign out_valid     = (phase == sssp_pkg::PH_NBR_STREAM) && r_valid;

   // In the stream each response beat is forwarded as a child, so the child
   // consumer throttles the response side
   always_comb begin
      r_ready = 1'b0;
      if (phase == sssp_pkg::PH_OFFS_WAIT) r_ready = 1'b1;
      else if (phase == sssp_pkg::PH_NBR_STREAM) r_ready = out_ready;
   end

   always_comb begin
      phase_d = phase;
      case (phase)
         sssp_pkg::PH_IDLE:       if (accept) phase_d = sssp_pkg::PH_RW;
         // Only one cycle to decide, the store was read combinationally
         sssp_pkg::PH_RW:         phase_d = improve ? sssp_pkg::PH_OFFS_REQ : sssp_pkg::PH_IDLE;
         sssp_pkg::PH_OFFS_REQ:   if (ar_ready) phase_d = sssp_pkg::PH_OFFS_WAIT;
         sssp_pkg::PH_OFFS_WAIT: begin
            if (r_valid) begin
               phase_d = range_empty ? sssp_pkg::PH_IDLE : sssp_pkg::PH_NBR_REQ; // Leaf node ends here
            end
         end
         sssp_pkg::PH_NBR_REQ:    if (ar_ready) phase_d = sssp_pkg::PH_NBR_STREAM;
         sssp_pkg::PH_NBR_STREAM: if (stream_beat && burst_last) phase_d = sssp_pkg::PH_IDLE;
         default:                 phase_d = sssp_pkg::PH_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         phase <= sssp_pkg::PH_IDLE;
      end else begin
         phase <= phase_d;
      end
   end

   // Task payload is captured once and held until the tile is idle again
   always_ff @(posedge clk) begin
      if (accept) cur_task <= in_task;
   end

endmodule

// File: hw/sssp_tile.sv
module sssp_tile (
   input  logic                   clk,
   input  logic                   rstn,

   input  logic                   task_in_valid,
   output logic                   task_in_ready,
   input  sssp_pkg::task_t        in_task,

   input  sssp_pkg::reg_bus_t     reg_bus,

   // Distance write, visible for checking
   output logic                   wvalid,
   output sssp_pkg::addr_t        waddr,
   output sssp_pkg::ts_t          wdata,

   output logic                   ar_valid,
   input  logic                   ar_ready,
   output sssp_pkg::ar_req_t      ar,

   input  logic                   r_valid,
   output logic                   r_ready,
   input  sssp_pkg::graph_word_t  r_data,

   output logic                   out_valid,
   input  logic                   out_ready,
   output sssp_pkg::task_t        out_task
);

   sssp_pkg::task_t    cur_task;
   sssp_pkg::phase_e   phase;
   sssp_pkg::rw_data_t cur_dist;

   logic improve;
   logic range_empty;
   logic burst_last;
   logic nbr_load;   // Neighbor read request accepted
   logic child_beat; // Child handed to the consumer

   assign nbr_load   = ar_valid && ar_ready && (phase == sssp_pkg::PH_NBR_REQ);
   assign child_beat = out_valid && out_ready;

   sssp_task_fsm fsm_inst (
      .clk           (clk),
      .rstn          (rstn),
      .task_in_valid (task_in_valid),
      .task_in_ready (task_in_ready),
      .in_task       (in_task),
      .cur_task      (cur_task),
      .improve       (improve),
      .ar_valid      (ar_valid),
      .ar_ready      (ar_ready),
      .r_valid       (r_valid),
      .r_ready       (r_ready),
      .range_empty   (range_empty),
      .out_ready     (out_ready),
      .out_valid     (out_valid),
      .burst_last    (burst_last),
      .phase         (phase)
   );

   sssp_burst_counter burst_inst (
      .clk      (clk),
      .rstn     (rstn),
      .load     (nbr_load),
      .load_len (ar.len),
      .beat     (child_beat),
      .last     (burst_last)
   );

   sssp_dist_store dist_inst (
      .clk     (clk),
      .rstn    (rstn),
      .rd_node (cur_task.object),
      .rd_dist (cur_dist),
      .we      (wvalid),
      .wr_node (cur_task.object),
      .wr_dist (wdata)
   );

   sssp_rw rw_inst (
      .clk      (clk),
      .rstn     (rstn),
      .reg_bus  (reg_bus),
      .phase    (phase),
      .cur_task (cur_task),
      .cur_dist (cur_dist),
      .improve  (improve),
      .wvalid   (wvalid),
      .waddr    (waddr),
      .wdata    (wdata)
   );

   sssp_ro ro_inst (
      .clk         (clk),
      .rstn        (rstn),
      .reg_bus     (reg_bus),
      .phase       (phase),
      .cur_task    (cur_task),
      .r_data      (r_data),
      .ar          (ar),
      .range_empty (range_empty),
      .out_task    (out_task)
   );

endmodule

// File: sim.f
hw/sssp_pkg.sv
hw/sssp_task_fsm.sv
hw/sssp_burst_counter.sv
hw/sssp_dist_store.sv
hw/sssp_rw.sv
hw/sssp_ro.sv
hw/sssp_tile.sv
tests/sssp_tile_tb.sv

// File: tests/sssp_tile_tb.sv
module sssp_tile_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD   = 10;
   localparam int RAND_TASKS   = 40;
   localparam int REBASE_TASKS = 24;
   localparam int TASK_CYCLES  = 300;                      // Worst case for one task under stalls
   localparam int WATCHDOG_CYC = (3 + RAND_TASKS + REBASE_TASKS) * TASK_CYCLES + 200;
   localparam int EMPTY_NODE   = sssp_pkg::NUM_NODES - 1;  // Always built with no edges
   localparam int MAX_EDGES    = 4 * sssp_pkg::NUM_NODES;

   logic clk, rstn, task_in_valid, task_in_ready, wvalid;
   logic ar_valid, ar_ready, r_valid, r_ready, out_valid, out_ready;
   sssp_pkg::task_t       in_task, out_task;
   sssp_pkg::reg_bus_t    reg_bus;
   sssp_pkg::addr_t       waddr;
   sssp_pkg::ts_t         wdata;
   sssp_pkg::ar_req_t     ar;
   sssp_pkg::graph_word_t r_data;

   sssp_pkg::graph_word_t mem [1024];                   // Graph memory, one entry per 8 bytes
   int                    nbr_start [sssp_pkg::NUM_NODES];
   int                    edge_cnt [sssp_pkg::NUM_NODES];
   int                    num_edges;
   sssp_pkg::node_t       nbr_node [MAX_EDGES];
   sssp_pkg::ts_t         nbr_w [MAX_EDGES];
   sssp_pkg::ts_t         model_dist [sssp_pkg::NUM_NODES];
   sssp_pkg::addr_t       rw_base, offs_base, nbr_base;   // Model copies of the base registers

   // What the model still expects from the DUT, oldest first
   sssp_pkg::addr_t   exp_waddr_q [$];
   sssp_pkg::ts_t     exp_wdata_q [$];
   sssp_pkg::ar_req_t exp_req_q [$];
   sssp_pkg::task_t   exp_child_q [$];
   sssp_pkg::addr_t   beat_q [$];                       // Response beats the memory still owes
   int errors = 0, checks = 0, tests = 0, seed_ret;

   sssp_tile sssp_tile_inst (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_task(input sssp_pkg::task_t got, input sssp_pkg::task_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t out_task got %h expected %h", $time, got, exp);
      end
   endtask

   task automatic check_req(input sssp_pkg::ar_req_t got, input sssp_pkg::ar_req_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t ar got addr %h len %0d expected addr %h len %0d",
                  $time, got.addr, got.len, exp.addr, exp.len);
      end
   endtask

   task automatic check_dist(input sssp_pkg::addr_t got_a, input sssp_pkg::addr_t exp_a,
                             input sssp_pkg::ts_t got_d, input sssp_pkg::ts_t exp_d);
      checks++;
      if (got_a !== exp_a || got_d !== exp_d) begin
         errors++;
         $display("FAIL %0t waddr/wdata got %h/%h expected %h/%h", $time, got_a, got_d, exp_a, exp_d);
      end
   endtask

   // Random adjacency lists of 0 to 4 edges, laid out back to back
   task automatic build_graph();
      num_edges = 0;
      for (int n = 0; n < sssp_pkg::NUM_NODES; n++) begin
         nbr_start[n] = num_edges;
         edge_cnt[n]  = (n == EMPTY_NODE) ? 0 : int'($urandom % 5);
         for (int e = 0; e < edge_cnt[n]; e++) begin
            nbr_node[num_edges] = $urandom % sssp_pkg::NUM_NODES;
            nbr_w[num_edges]    = 1 + ($urandom % 50);
            num_edges++;
         end
      end
   endtask

   task automatic load_memory();
      sssp_pkg::addr_t a;
      for (int i = 0; i < 1024; i++) begin
         a = i * 8;
         mem[i] = {~a, a};                               // Stale reads show their own address
      end
      for (int n = 0; n < sssp_pkg::NUM_NODES; n++) begin
         a = offs_base + n * 8;
         mem[a[12:3]] = {32'(nbr_start[n] + edge_cnt[n]), 32'(nbr_start[n])};
      end
      for (int k = 0; k < num_edges; k++) begin
         a = nbr_base + k * 8;
         mem[a[12:3]] = {nbr_w[k], nbr_node[k]};
      end
   endtask

   task automatic write_reg(input logic [7:0] a, input logic [31:0] d);
      reg_bus <= {1'b1, a, d};
      @(posedge clk);
      reg_bus <= '0;
      @(posedge clk);
   endtask

   // Registers hold word addresses, so each base is four times the written value
   task automatic set_bases(input logic [31:0] rw_word, input logic [31:0] offs_word,
                            input logic [31:0] nbr_word);
      write_reg(sssp_pkg::REG_RW_BASE, rw_word);
      write_reg(sssp_pkg::REG_OFFSET_BASE, offs_word);
      write_reg(sssp_pkg::REG_NBR_BASE, nbr_word);
      rw_base   = rw_word << 2;
      offs_base = offs_word << 2;
      nbr_base  = nbr_word << 2;
      load_memory();                                     // Graph moves with the bases
   endtask

   // Queues up everything an accepted task should produce and reports whether it improves
   function automatic logic predict(input sssp_pkg::task_t t);
      sssp_pkg::ar_req_t req;
      sssp_pkg::task_t   child;
      int n;
      n = int'(t.object % sssp_pkg::NUM_NODES);
      if (t.ts >= model_dist[n]) return 1'b0;          // Equal or worse is dropped
      model_dist[n] = t.ts;
      exp_waddr_q.push_back(rw_base + t.object * 4);
      exp_wdata_q.push_back(t.ts);
      req.addr = offs_base + t.object * 8;
      req.len  = '0;
      exp_req_q.push_back(req);
      if (edge_cnt[n] == 0) return 1'b1;               // Leaf stops after the offset read
      req.addr = nbr_base + nbr_start[n] * 8;
      req.len  = edge_cnt[n] - 1;
      exp_req_q.push_back(req);
      for (int k = nbr_start[n]; k < nbr_start[n] + edge_cnt[n]; k++) begin
         child.ts     = t.ts + nbr_w[k];
         child.object = nbr_node[k];
         child.ttype  = sssp_pkg::CHILD_TTYPE;
         exp_child_q.push_back(child);
      end
      return 1'b1;
   endfunction

   // Called on an idle edge, returns on the edge where the input is free again
   task automatic run_task(input sssp_pkg::node_t node, input sssp_pkg::ts_t ts);
      sssp_pkg::task_t t;
      logic improves;
      int lat;
      t.ts     = ts;
      t.object = node;
      t.ttype  = $urandom % 16;
      task_in_valid <= 1'b1;
      in_task       <= t;
      do @(posedge clk); while (!task_in_ready);
      task_in_valid <= 1'b0;
      improves = predict(t);
      lat = 0;
      do begin
         @(posedge clk);
         lat++;
      end while (!task_in_ready);
      if (!improves) begin
         checks++;
         if (lat != 2) begin
            errors++;
            $display("Non-improving task kept the input busy for %0d cycles instead of 2", lat);
         end
      end
   endtask

   task automatic finish_test(input string name, input int err_start);
      if (exp_waddr_q.size() != 0 || exp_req_q.size() != 0 || exp_child_q.size() != 0) begin
         errors++;
         $display("Test %s ended with %0d writes, %0d reads and %0d children never seen", name,
                  exp_waddr_q.size(), exp_req_q.size(), exp_child_q.size());
      end
      tests++;
      if (errors == err_start) $display("test %-7s ok", name);
      else $display("test %-7s %0d errors", name, errors - err_start);
   endtask

   // Graph memory with random request acceptance, response gaps and child back-pressure
   always @(posedge clk) begin
      sssp_pkg::addr_t a;
      if (!rstn) begin
         ar_ready  <= 1'b0;
         r_valid   <= 1'b0;
         out_ready <= 1'b0;
         beat_q.delete();
      end else begin
         if (r_valid && r_ready) void'(beat_q.pop_front());
         if (ar_valid && ar_ready) begin
            for (int b = 0; b <= int'(ar.len); b++) beat_q.push_back(ar.addr + b * 8);
         end
         if (!(r_valid && !r_ready)) begin             // A stalled beat stays on the bus
            if (beat_q.size() != 0 && ($urandom % 3) != 0) begin
               a = beat_q[0];
               r_valid <= 1'b1;
               r_data  <= mem[a[12:3]];
            end else begin
               r_valid <= 1'b0;
            end
         end
         ar_ready  <= ($urandom % 2) == 0;
         out_ready <= ($urandom % 4) != 0;
      end
   end

   always @(posedge clk) begin
      if (rstn && wvalid) begin
         if (exp_waddr_q.size() == 0) begin
            errors++;
            $display("Distance write at %0t when none was expected", $time);
         end else check_dist(waddr, exp_waddr_q.pop_front(), wdata, exp_wdata_q.pop_front());
      end
      if (rstn && ar_valid && ar_ready) begin
         if (exp_req_q.size() == 0) begin
            errors++;
            $display("Graph read at %0t when none was expected", $time);
         end else check_req(ar, exp_req_q.pop_front());
      end
      if (rstn && out_valid && out_ready) begin
         if (exp_child_q.size() == 0) begin
            errors++;
            $display("Child task at %0t when none was expected", $time);
         end else check_task(out_task, exp_child_q.pop_front());
      end
   end

   initial begin
      #(WATCHDOG_CYC * CLK_PERIOD);
      $display("Watchdog expired before the tests finished");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      sssp_pkg::node_t node;
      int err_start;
      rstn          = 1'b0;
      task_in_valid = 1'b0;
      in_task       = '0;
      reg_bus       = '0;
      ar_ready      = 1'b0;
      r_valid       = 1'b0;
      r_data        = '0;
      out_ready     = 1'b0;
      seed_ret = $urandom(32'h26d870fe);
      build_graph();
      for (int n = 0; n < sssp_pkg::NUM_NODES; n++) model_dist[n] = sssp_pkg::DIST_INF;
      repeat (5) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);

      err_start = errors;
      checks++;
      if (task_in_ready !== 1'b1 || wvalid !== 1'b0 || ar_valid !== 1'b0 ||
          r_ready !== 1'b0 || out_valid !== 1'b0) begin
         errors++;
         $display("Control outputs were not idle after reset");
      end
      finish_test("reset", err_start);

      set_bases(32'h400, 32'h40, 32'h80);
      err_start = errors;
      node = $urandom % (sssp_pkg::NUM_NODES - 1);   // Keeps the leaf node untouched
      run_task(node, $urandom % 1000);
      finish_test("first", err_start);

      err_start = errors;
      run_task(node, model_dist[node] + ($urandom % 4));
      finish_test("stale", err_start);

      err_start = errors;
      run_task(EMPTY_NODE, $urandom % 1000);
      finish_test("leaf", err_start);

      err_start = errors;
      repeat (RAND_TASKS) run_task($urandom % sssp_pkg::NUM_NODES, $urandom % 1000);
      finish_test("random", err_start);

      // Lower timestamps here so most tasks improve and exercise the new bases
      err_start = errors;
      set_bases(32'h123, 32'h200, 32'h2c0);
      repeat (REBASE_TASKS) run_task($urandom % sssp_pkg::NUM_NODES, $urandom % 200);
      finish_test("rebase", err_start);

      $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
      if (errors == 0) $display("Simulation passed");
      else $display("Simulation failed");
      $finish;
   end

endmodule
